//--- project.f
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
cpu_top.sv
cpu_chk.sv
cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - fetch_stage.sv
      - decode_stage.sv
      - execute_stage.sv
      - memory_stage.sv
      - hazard_unit.sv
      - cpu_top.sv
      - target: test
        files:
          - cpu_chk.sv
          - cpu_tb.sv

//--- cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;
    localparam int progLen = 120;

    // instruction kinds known to the generator and the reference model
    localparam logic [2:0] kAlu = 3'd0;
    localparam logic [2:0] kAddi = 3'd1;
    localparam logic [2:0] kLui = 3'd2;
    localparam logic [2:0] kLoad = 3'd3;
    localparam logic [2:0] kStore = 3'd4;
    localparam logic [2:0] kBeq = 3'd5;
    localparam logic [2:0] kBne = 3'd6;
    localparam logic [2:0] kJal = 3'd7;

    typedef struct packed {
        logic [2:0]  kind;
        logic [2:0]  op;      // add, sub, and, or, xor, slt for register ALU ops
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } instrT;

    logic        clk;
    logic        rst;
    logic        progWe;
    logic [7:0]  progAddr;
    logic [31:0] progData;
    logic [15:0] switches;
    logic [15:0] led;
    logic        ledWrite;

    integer      seed;
    logic [31:0] prog [progLen];
    instrT       fields [progLen];
    logic [15:0] switchSeq [progLen + 1];   // switch value held after each LED write
    logic [15:0] expLed [$];
    int          progCount;
    int          ledCount;
    int          expCount;
    int          i;

    cpu_top uut (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .switches(switches), .led(led), .ledWrite(ledWrite)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int randRange(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    task automatic abortRun;
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail: %s got 0x%h expected 0x%h", name, got, exp);
            abortRun();
        end
    endtask

    // encodes one RV32I word and keeps its fields for the model
    task automatic appendInstr(input logic [2:0] k, input logic [2:0] op, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [31:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'b000;
        f7 = 7'b0;
        case (k)
            kAlu: begin
                case (op)
                    3'd1: f7 = 7'h20;   // SUB shares funct3 with ADD
                    3'd2: f3 = 3'b111;
                    3'd3: f3 = 3'b110;
                    3'd4: f3 = 3'b100;
                    3'd5: f3 = 3'b010;
                    default: ;
                endcase
                prog[progCount] = {f7, rs2, rs1, f3, rd, 7'h33};
            end
            kAddi: prog[progCount] = {imm[11:0], rs1, 3'b000, rd, 7'h13};
            kLui: prog[progCount] = {imm[31:12], rd, 7'h37};
            kLoad: prog[progCount] = {imm[11:0], rs1, 3'b010, rd, 7'h03};
            kStore: prog[progCount] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
            kBeq, kBne: begin
                f3 = (k == kBne) ? 3'b001 : 3'b000;
                prog[progCount] = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
            end
            default: prog[progCount] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
        endcase
        fields[progCount] = '{kind: k, op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
        progCount = progCount + 1;
    endtask

    // x7 is the only base register, so it always holds 0 or the I/O address
    task automatic setBase(input logic [31:0] base);
        appendInstr(kLui, 0, 7, 0, 0, base);
        appendInstr(kAddi, 0, 7, 7, 0, 0);
    endtask

    task automatic buildProgram;
        int choice;
        int size;
        int rd;
        int rs;
        int off;
        progCount = 0;
        for (int r = 1; r <= 6; r++) begin
            appendInstr(kAddi, 0, r, 0, 0, randRange(-2048, 2047));
        end
        setBase(32'h0);
        for (int w = 0; w < 4; w++) begin
            appendInstr(kStore, 0, 0, 7, 0, w * 4);    // clear the data words that loads use
        end
        while (progCount < progLen - 4) begin
            choice = randRange(0, 7);
            rd = randRange(1, 6);
            rs = randRange(1, 7);
            size = (choice == 4) ? 3 : (choice == 5) ? 5 : (choice == 6) ? 4 : 1;
            if (progCount + size > progLen - 4) begin
                choice = 0;
            end
            case (choice)
                0, 1, 2: appendInstr(kAlu, randRange(0, 5), rd, rs, randRange(1, 7), 0);
                3: begin
                    if (randRange(0, 1) == 1) begin
                        appendInstr(kLui, 0, rd, 0, 0, randRange(0, 32'hfffff) << 12);
                    end else begin
                        appendInstr(kAddi, 0, rd, rs, 0, randRange(-2048, 2047));
                    end
                end
                4: begin
                    setBase(`IO_ADDR);
                    appendInstr(kStore, 0, 0, 7, rs, 0);
                end
                5: begin
                    setBase(`IO_ADDR);
                    appendInstr(kStore, 0, 0, 7, rs, 0);     // marker before the switch read
                    appendInstr(kLoad, 0, rd, 7, 0, 0);
                    appendInstr(kStore, 0, 0, 7, rd, 0);
                end
                6: begin
                    off = randRange(0, 3) * 4;
                    setBase(32'h0);
                    appendInstr(kStore, 0, 0, 7, rs, off);
                    appendInstr(kLoad, 0, rd, 7, 0, off);    // load right behind its store
                end
                default: begin
                    choice = randRange(kBeq, kJal);
                    appendInstr(choice, 0, (choice == kJal) ? rd : 0, rs, randRange(1, 7),
                                randRange(2, 4) * 4);
                end
            endcase
        end
        setBase(`IO_ADDR);
        appendInstr(kStore, 0, 0, 7, randRange(1, 6), 0);
        appendInstr(kJal, 0, 0, 0, 0, 0);
    endtask

    // sequential ISA model producing the ordered LED values
    task automatic runModel;
        logic [31:0] regs [8];
        logic [31:0] dmem [`DMEM_DEPTH];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        int          pc;
        int          next;
        instrT       f;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        expCount = 0;
        pc = 0;
        f = fields[0];
        while (prog[pc] != `HALT_INSN) begin
            a = regs[f.rs1];
            b = regs[f.rs2];
            addr = a + f.imm;
            res = '0;
            next = pc + 1;
            case (f.kind)
                kAlu: begin
                    case (f.op)
                        3'd0: res = a + b;
                        3'd1: res = a - b;
                        3'd2: res = a & b;
                        3'd3: res = a | b;
                        3'd4: res = a ^ b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                kAddi: res = a + f.imm;
                kLui: res = f.imm;
                kLoad: begin
                    if (addr == `IO_ADDR) begin
                        res = {16'b0, switchSeq[expCount]};
                    end else begin
                        res = dmem[(addr >> 2) % `DMEM_DEPTH];
                    end
                end
                kStore: begin
                    if (addr == `IO_ADDR) begin
                        expLed.push_back(b[15:0]);
                        expCount = expCount + 1;
                    end else begin
                        dmem[(addr >> 2) % `DMEM_DEPTH] = b;
                    end
                end
                kBeq: next = (a == b) ? pc + int'(f.imm / 4) : next;
                kBne: next = (a != b) ? pc + int'(f.imm / 4) : next;
                default: begin
                    res = pc * 4 + 4;
                    next = pc + int'(f.imm / 4);
                end
            endcase
            if (f.rd != 5'd0) begin
                regs[f.rd] = res;     // stores and branches carry rd 0
            end
            pc = next;
            f = fields[pc];
        end
    endtask

    // every LED write is checked in order, then the next switch value goes out
    always @(negedge clk) begin
        if (!rst && ledWrite) begin
            if (ledCount >= expCount) begin
                $display("LED write number %0d was not expected by the model", ledCount + 1);
                abortRun();
            end
            checkValue("led", led, expLed[ledCount]);
            ledCount = ledCount + 1;
            switches = switchSeq[ledCount];
        end
    end

    initial begin
        @(negedge rst);
        repeat (progLen * 4 + 200) @(posedge clk);
        $display("timeout, the program did not finish its LED writes in time");
        abortRun();
    end

    initial begin
        seed = 32'h3d38fa21;
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        switches = '0;
        ledCount = 0;
        for (i = 0; i <= progLen; i++) begin
            switchSeq[i] = $random(seed);
        end
        buildProgram();
        runModel();
        switches = switchSeq[0];
        for (i = 0; i < progLen; i++) begin
            @(negedge clk);
            progWe = 1'b1;
            progAddr = i;
            progData = prog[i];
        end
        @(negedge clk);
        progWe = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        wait (ledCount == expCount);
        repeat (50) @(negedge clk);      // halt must stay quiet
        $display("Done: no errors");
        $finish;
    end
endmodule

//--- cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
    input logic        clk,
    input logic        rst,
    input logic        ledWrite,
    input logic        stall,
    input logic        flush,
    input logic        redirect,
    input logic        decValid,
    input logic [31:0] decInstr,
    input logic        exValid
);
    // ledWrite is cleared on the first reset edge and stays low after that
    ledQuietInReset: assert property (@(posedge clk) rst && $past(rst) |-> !ledWrite)
        else $error("ledWrite pulsed while the core was in reset");

    // a load-use stall keeps the word in decode and sends a bubble into execute
    stallHoldsDecode: assert property (@(posedge clk) disable iff (rst)
        stall |=> !exValid && $stable(decInstr) && $stable(decValid))
        else $error("stall did not hold decode while inserting a bubble");

    // both younger instructions behind a taken branch become bubbles
    flushSquashesYounger: assert property (@(posedge clk) disable iff (rst)
        flush |=> !exValid && !decValid)
        else $error("flush left a younger instruction valid");

    // the two squashed slots reach execute as bubbles and must not redirect fetch
    redirectNotFromBubble: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !redirect [*2])
        else $error("redirect raised by a bubble in execute");
endmodule

bind cpu_top cpu_chk chk (
    .clk(clk), .rst(rst), .ledWrite(ledWrite), .stall(stall),
    .flush(flushEx), .redirect(redirect), .decValid(ifId.valid),
    .decInstr(ifId.instr), .exValid(idEx.valid)
);

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        progWe,
    input  logic [7:0]  progAddr,
    input  logic [31:0] progData,
    input  logic [15:0] switches,
    output logic [15:0] led,
    output logic        ledWrite
);
    cpu_pkg::ifIdT  ifId;
    cpu_pkg::idExT  idEx;
    cpu_pkg::exMemT exMem;
    cpu_pkg::memWbT memWb;
    logic           stall;
    logic           flushId;
    logic           flushEx;
    logic           redirect;
    logic [31:0]    target;
    logic [1:0]     fwdA;
    logic [1:0]     fwdB;
    logic [4:0]     decRs1;
    logic [4:0]     decRs2;

    fetch_stage fetch (
        .clk(clk), .rst(rst), .stall(stall), .flush(flushId),
        .redirect(redirect), .target(target),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .ifId(ifId)
    );

    decode_stage decode (
        .clk(clk), .rst(rst), .stall(stall), .flush(flushEx),
        .ifId(ifId), .wb(memWb), .idEx(idEx), .rs1(decRs1), .rs2(decRs2)
    );

    execute_stage execute (
        .clk(clk), .rst(rst), .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
        .exMemFwd(exMem), .wbFwd(memWb), .redirect(redirect), .target(target)
    );

    memory_stage memStage (
        .clk(clk), .rst(rst), .exMem(exMem), .switches(switches),
        .memWb(memWb), .led(led), .ledWrite(ledWrite)
    );

    hazard_unit hazard (
        .decRs1(decRs1), .decRs2(decRs2), .exRs1(idEx.rs1), .exRs2(idEx.rs2),
        .idEx(idEx), .exMem(exMem), .memWb(memWb), .redirect(redirect),
        .stall(stall), .flushId(flushId), .flushEx(flushEx),
        .fwdA(fwdA), .fwdB(fwdB)
    );
endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0]      decRs1,
    input  logic [4:0]      decRs2,
    input  logic [4:0]      exRs1,
    input  logic [4:0]      exRs2,
    input  cpu_pkg::idExT   idEx,
    input  cpu_pkg::exMemT  exMem,
    input  cpu_pkg::memWbT  memWb,
    input  logic            redirect,
    output logic            stall,
    output logic            flushId,
    output logic            flushEx,
    output logic [1:0]      fwdA,
    output logic [1:0]      fwdB
);
    logic loadUse;

    // the younger producer wins, x0 is never forwarded
    function automatic logic [1:0] fwdSel(input logic [4:0] src);
        if (exMem.valid && exMem.regWrite && exMem.rd != 5'd0 && exMem.rd == src) begin
            fwdSel = 2'b10;
        end else if (memWb.regWrite && memWb.rd != 5'd0 && memWb.rd == src) begin
            fwdSel = 2'b01;
        end else begin
            fwdSel = 2'b00;
        end
    endfunction

    always_comb begin
        fwdA = fwdSel(exRs1);
        fwdB = fwdSel(exRs2);
    end

    // load data is only ready after the memory stage, so the consumer waits one cycle
    assign loadUse = idEx.ctrl.memRead && idEx.rd != 5'd0 &&
                     (idEx.rd == decRs1 || idEx.rd == decRs2);

    assign stall = loadUse && !redirect;  // a taken branch discards the consumer anyway
    assign flushId = redirect;
    assign flushEx = redirect;
endmodule

//--- memory_stage.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module memory_stage (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::exMemT  exMem,
    input  logic [15:0]     switches,
    output cpu_pkg::memWbT  memWb,
    output logic [15:0]     led,
    output logic            ledWrite
);
    localparam int idxWidth = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0]    dmem [`DMEM_DEPTH];
    logic [`XLEN-1:0]    loadData;
    logic [idxWidth-1:0] wordIdx;
    logic                isIo;
    logic                doStore;

    assign isIo = (exMem.aluResult == `IO_ADDR);
    assign wordIdx = exMem.aluResult[idxWidth+1:2];   // word accesses only
    assign doStore = exMem.valid && exMem.memWrite;

    // the switches sit in the low half of the I/O word
    assign loadData = isIo ? {16'b0, switches} : dmem[wordIdx];

    always_ff @(posedge clk) begin
        if (doStore && !isIo) begin
            dmem[wordIdx] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
            ledWrite <= 1'b0;
        end else begin
            ledWrite <= doStore && isIo;    // one pulse per LED store
            if (doStore && isIo) begin
                led <= exMem.storeData[15:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb.regWrite <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.valid && exMem.regWrite;
            memWb.rd <= exMem.rd;
            memWb.result <= exMem.memRead ? loadData : exMem.aluResult;
        end
    end
endmodule

//--- execute_stage.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::idExT   idEx,
    input  logic [1:0]      fwdA,
    input  logic [1:0]      fwdB,
    output cpu_pkg::exMemT  exMemFwd,
    input  cpu_pkg::memWbT  wbFwd,
    output logic            redirect,
    output logic [31:0]     target
);
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] pcPlus4;
    logic             branchHit;

    // select 2 is EX/MEM, 1 is MEM/WB, anything else keeps the register file value
    function automatic logic [`XLEN-1:0] fwdMux(input logic [1:0] sel,
                                                 input logic [`XLEN-1:0] regVal,
                                                 input logic [`XLEN-1:0] exVal,
                                                 input logic [`XLEN-1:0] wbVal);
        case (sel)
            2'b10: fwdMux = exVal;
            2'b01: fwdMux = wbVal;
            default: fwdMux = regVal;
        endcase
    endfunction

    assign opA = fwdMux(fwdA, idEx.rs1Val, exMemFwd.aluResult, wbFwd.result);
    assign opB = fwdMux(fwdB, idEx.rs2Val, exMemFwd.aluResult, wbFwd.result);
    assign aluB = idEx.ctrl.useImm ? idEx.imm : opB;
    assign pcPlus4 = idEx.pc + 32'd4;

    always_comb begin
        case (idEx.ctrl.aluOp)
            cpu_pkg::aluSub: aluOut = opA - aluB;
            cpu_pkg::aluAnd: aluOut = opA & aluB;
            cpu_pkg::aluOr: aluOut = opA | aluB;
            cpu_pkg::aluXor: aluOut = opA ^ aluB;
            cpu_pkg::aluSlt: aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            cpu_pkg::aluPassB: aluOut = aluB;
            default: aluOut = opA + aluB;
        endcase
    end

    // branches compare the forwarded register values, never the immediate
    assign branchHit = (opA == opB) ^ idEx.ctrl.branchNe;
    assign redirect = idEx.valid && (idEx.ctrl.isJal || (idEx.ctrl.isBranch && branchHit));
    assign target = idEx.pc + idEx.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            exMemFwd.valid <= 1'b0;
            exMemFwd.memRead <= 1'b0;
            exMemFwd.memWrite <= 1'b0;
            exMemFwd.regWrite <= 1'b0;
        end else begin
            exMemFwd.valid <= idEx.valid;
            exMemFwd.memRead <= idEx.ctrl.memRead;
            exMemFwd.memWrite <= idEx.ctrl.memWrite;
            exMemFwd.regWrite <= idEx.ctrl.regWrite;
            exMemFwd.rd <= idEx.rd;
            exMemFwd.aluResult <= idEx.ctrl.isJal ? pcPlus4 : aluOut;  // link value
            exMemFwd.storeData <= opB;
        end
    end
endmodule

//--- decode_stage.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module decode_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  cpu_pkg::ifIdT   ifId,
    input  cpu_pkg::memWbT  wb,
    output cpu_pkg::idExT   idEx,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2
);
    logic [`XLEN-1:0] regFile [32];
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [2:0]       funct3;
    cpu_pkg::opcodeE  opcode;
    cpu_pkg::ctrlT    ctrl;

    assign instr = ifId.instr;
    assign opcode = cpu_pkg::opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        ctrl = '0;
        imm = '0;
        case (opcode)
            cpu_pkg::opcOp: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = instr[30] ? cpu_pkg::aluSub : cpu_pkg::aluAdd;
                    3'b010: ctrl.aluOp = cpu_pkg::aluSlt;
                    3'b100: ctrl.aluOp = cpu_pkg::aluXor;
                    3'b110: ctrl.aluOp = cpu_pkg::aluOr;
                    3'b111: ctrl.aluOp = cpu_pkg::aluAnd;
                    default: ctrl.regWrite = 1'b0;    // shifts and SLTU are not supported
                endcase
            end
            cpu_pkg::opcOpImm: begin
                ctrl.regWrite = (funct3 == 3'b000);   // ADDI only
                ctrl.useImm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            cpu_pkg::opcLui: begin
                ctrl.aluOp = cpu_pkg::aluPassB;
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
                imm = {instr[31:12], 12'b0};
            end
            cpu_pkg::opcLoad: begin
                ctrl.useImm = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            cpu_pkg::opcStore: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            cpu_pkg::opcBranch: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchNe = funct3[0];
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            cpu_pkg::opcJal: begin
                ctrl.isJal = 1'b1;
                ctrl.regWrite = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;
        endcase
        if (!ifId.valid) begin
            ctrl = '0;    // a bubble must never write anything downstream
        end
    end

    // write-through so an instruction in decode sees the value retiring this cycle
    assign rs1Val = (rs1 == 5'd0) ? '0 :
                    (wb.regWrite && wb.rd == rs1) ? wb.result : regFile[rs1];
    assign rs2Val = (rs2 == 5'd0) ? '0 :
                    (wb.regWrite && wb.rd == rs2) ? wb.result : regFile[rs2];

    always_ff @(posedge clk) begin
        if (wb.regWrite && wb.rd != 5'd0) begin
            regFile[wb.rd] <= wb.result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush || stall) begin
            idEx.valid <= 1'b0;   // stall leaves ifId held upstream and sends a bubble on
            idEx.ctrl <= '0;
        end else begin
            idEx.valid <= ifId.valid;
            idEx.ctrl <= ctrl;
            idEx.pc <= ifId.pc;
            idEx.rs1Val <= rs1Val;
            idEx.rs2Val <= rs2Val;
            idEx.imm <= imm;
            idEx.rs1 <= rs1;
            idEx.rs2 <= rs2;
            idEx.rd <= instr[11:7];
        end
    end
endmodule

//--- fetch_stage.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             flush,
    input  logic             redirect,
    input  logic [31:0]      target,
    input  logic             progWe,
    input  logic [7:0]       progAddr,
    input  logic [31:0]      progData,
    output cpu_pkg::ifIdT    ifId
);
    localparam int idxWidth = $clog2(`IMEM_DEPTH);

    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;

    assign instr = imem[pc[idxWidth+1:2]];    // word aligned fetch

    // the program is loaded only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ifId.valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= target;
            end else if (!stall) begin
                pc <= pc + 32'd4;
            end
            if (flush) begin
                ifId.valid <= 1'b0;   // wrong-path word behind a taken branch
            end else if (!stall) begin
                ifId.pc <= pc;
                ifId.instr <= instr;
                ifId.valid <= 1'b1;
            end
        end
    end
endmodule

//--- cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB    // LUI just passes the immediate through
    } aluOpE;

    // major opcodes of the RV32I subset we decode
    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,
        opcOpImm  = 7'b0010011,
        opcLui    = 7'b0110111,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011,
        opcJal    = 7'b1101111
    } opcodeE;

    typedef struct packed {
        aluOpE aluOp;
        logic  useImm;
        logic  memRead;
        logic  memWrite;
        logic  regWrite;
        logic  isBranch;
        logic  branchNe;    // set for BNE, clear for BEQ
        logic  isJal;
    } ctrlT;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
        logic             valid;
    } ifIdT;

    typedef struct packed {
        ctrlT             ctrl;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1Val;
        logic [`XLEN-1:0] rs2Val;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic             valid;
    } idExT;

    typedef struct packed {
        logic             memRead;
        logic             memWrite;
        logic             regWrite;
        logic [4:0]       rd;
        logic [`XLEN-1:0] aluResult;   // holds pc+4 for JAL
        logic [`XLEN-1:0] storeData;
        logic             valid;
    } exMemT;

    typedef struct packed {
        logic             regWrite;
        logic [4:0]       rd;
        logic [`XLEN-1:0] result;
    } memWbT;

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register width
`define XLEN 32

// instruction memory words, filled through the program-load port
`define IMEM_DEPTH 256

// data memory words
`define DMEM_DEPTH 256

// byte address of the shared switch/LED word (word address 0x400)
`define IO_ADDR 32'h0000_1000

// JAL x0,0 jumps onto itself and is what software uses to stop
`define HALT_INSN 32'h0000_006f

`endif
